//--- sources.f
+incdir+logic
logic/isa_pkg.sv
logic/datapath_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/register_bank.sv
logic/memory_array.sv
logic/accumulator_cpu.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cpu_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/cpu_tb.sv
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;
    import isa_pkg::*;
    import datapath_pkg::*;

    localparam int DONE_TIMEOUT = 5000;
    localparam int DATA_WORDS   = 32;

    logic  clk;
    logic  reset;
    logic  run;
    logic  host_we;
    logic  host_sel;
    addr_t host_addr;
    word_t host_wdata;
    word_t host_rdata;
    logic  busy;
    logic  done;
    word_t ac;
    logic  rd_check;
    int    pass_count;
    int    fail_count;

    logic [15:0] lfsr;
    word_t       prog [$];
    word_t       data [DATA_WORDS];
    int          test_num;
    int          tb_errors;
    logic        aborted;

    always #10 clk = ~clk;

    accumulator_cpu dut (
        .clk, .reset, .run, .host_we, .host_sel, .host_addr, .host_wdata,
        .host_rdata, .busy, .done, .ac
    );

    cpu_checker u_checker (
        .clk, .reset, .run, .host_we, .host_sel, .host_addr, .host_wdata,
        .host_rdata, .rd_check, .busy, .done, .ac, .pass_count, .fail_count
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic void emit(logic [`CPU_OPC_W-1:0] op, int field);
        prog.push_back({op, field[`CPU_ADDR_W-1:0]});
    endfunction

    // ac op mem[operand], result parked in mem[dest], ac keeps the result
    function automatic void emit_alu(logic [`CPU_OPC_W-1:0] op, int operand, int dest);
        emit(OP_MVACR2, 0);
        emit(OP_LDIAC, operand);
        emit(OP_MVAC, 0);
        emit(OP_MVR2AC, 0);
        emit(op, 0);
        emit(OP_MVACR1, 0);
        emit(OP_LDIAC, dest);
        emit(OP_MVR1AC, 0);
        emit(OP_STAC, 0);
    endfunction

    function automatic void new_program();
        int i;
        prog.delete();
        for (i = 0; i < DATA_WORDS; i++) begin
            data[i] = rand_bits(16);
        end
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic host_write(logic sel, addr_t addr, word_t value);
        @(negedge clk);
        host_we    = 1'b1;
        host_sel   = sel;
        host_addr  = addr;
        host_wdata = value;
    endtask

    task automatic host_idle();
        @(negedge clk);
        host_we  = 1'b0;
        rd_check = 1'b0;
    endtask

    task automatic fill_memories();
        int i;
        for (i = 0; i < `CPU_IM_DEPTH; i++) begin
            host_write(1'b0, addr_t'(i), {OP_END, addr_t'(i)});  // stray fetches end
            host_write(1'b1, addr_t'(i), word_t'(i) * 16'h9e37 ^ 16'h2c1b);
        end
        host_idle();
    endtask

    task automatic run_test(string name);
        int fails_before;
        int cycles;
        int i;
        if (aborted) begin
            return;
        end
        test_num++;
        fails_before = fail_count;
        apply_reset();
        for (i = 0; i < prog.size(); i++) begin
            host_write(1'b0, addr_t'(i), prog[i]);
        end
        for (i = 0; i < DATA_WORDS; i++) begin
            host_write(1'b1, addr_t'(i), data[i]);
        end
        host_idle();
        run = 1'b1;
        @(negedge clk);
        run    = 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("test %0d %s: done did not rise within %0d cycles", test_num, name,
                     DONE_TIMEOUT);
            tb_errors++;
            aborted = 1'b1;
            return;
        end
        for (i = 0; i < DATA_WORDS; i++) begin
            @(negedge clk);
            host_sel  = 1'b1;
            host_addr = addr_t'(i);
            rd_check  = 1'b1;
        end
        host_idle();
        if (fail_count == fails_before) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, fail_count - fails_before);
        end
    endtask

    task automatic load_store_test();
        new_program();
        data[0] = 16'd8 + rand_bits(3);   // pointer for ldac
        data[1] = 16'd16 + rand_bits(3);  // pointer for mvacar
        emit(OP_LDIAC, 0);
        emit(OP_LDAC, 0);
        emit(OP_MVACR1, 0);
        emit(OP_LDIAC, 2);
        emit(OP_MVACR2, 0);
        emit(OP_LDIAC, 3);
        emit(OP_MVACR3, 0);
        emit(OP_LDIAC, 4);
        emit(OP_MVACR4, 0);
        emit(OP_LDIAC, 5);
        emit(OP_MVAC, 0);
        emit(OP_LDIAC, 1);
        emit(OP_MVACAR, 0);
        emit(OP_MVR1AC, 0);
        emit(OP_STAC, 0);
        emit(OP_LDIAC, 24);
        emit(OP_MVR2AC, 0);
        emit(OP_STAC, 0);
        emit(OP_LDIAC, 25);
        emit(OP_MVR3AC, 0);
        emit(OP_STAC, 0);
        emit(OP_LDIAC, 26);
        emit(OP_MVR4AC, 0);
        emit(OP_STAC, 0);
        emit(OP_END, 0);
        run_test("load store move");
    endtask

    task automatic alu_test();
        new_program();
        emit(OP_LDIAC, 0);
        emit_alu(OP_ADD, 1, 20);
        emit_alu(OP_SUB, 2, 21);
        emit_alu(OP_MULT, 3, 22);
        emit_alu(OP_LSHIFT, 4, 23);
        emit(OP_INAC, 0);
        emit(OP_MVACR1, 0);
        emit(OP_LDIAC, 24);
        emit(OP_MVR1AC, 0);
        emit(OP_STAC, 0);
        emit(OP_CLAC, 0);
        emit(OP_INAC, 0);
        emit(OP_END, 0);
        run_test("alu");
    endtask

    task automatic branch_test();
        new_program();
        data[0] = data[0] | 16'd1;      // nonzero ac for the first jumps
        emit(OP_LDIAC, 0);
        emit(OP_JPNZ, 5);    // taken
        emit(OP_LDIAC, 1);
        emit(OP_INAC, 0);
        emit(OP_STAC, 0);
        emit(OP_JMPZ, 9);    // not taken
        emit(OP_LDIAC, 2);
        emit(OP_INAC, 0);
        emit(OP_STAC, 0);
        emit(OP_CLAC, 0);
        emit(OP_JPNZ, 14);   // not taken
        emit(OP_LDIAC, 3);
        emit(OP_INAC, 0);
        emit(OP_STAC, 0);
        emit(OP_CLAC, 0);
        emit(OP_JMPZ, 19);   // taken
        emit(OP_LDIAC, 4);
        emit(OP_INAC, 0);
        emit(OP_STAC, 0);
        emit(OP_LDIAC, 5);
        emit(OP_INAC, 0);
        emit(OP_STAC, 0);
        emit(OP_END, 0);
        run_test("branches");
    endtask

    task automatic countdown_test();
        new_program();
        data[0] = 16'd1 + rand_bits(16) % 16'd19;
        data[1] = '0;
        data[2] = 16'd1;
        emit(OP_LDIAC, 0);
        emit(OP_MVACR1, 0);  // r1 counts down
        emit(OP_LDIAC, 1);   // loop head
        emit(OP_MVAC, 0);
        emit(OP_MVR1AC, 0);
        emit(OP_ADD, 0);
        emit(OP_STAC, 0);
        emit(OP_LDIAC, 2);
        emit(OP_MVAC, 0);
        emit(OP_MVR1AC, 0);
        emit(OP_SUB, 0);
        emit(OP_MVACR1, 0);
        emit(OP_JPNZ, 2);
        emit(OP_END, 0);
        run_test("countdown loop");
    endtask

    task automatic random_program_test();
        int len;
        int i;
        int pick;
        int target;
        new_program();
        len = 12 + int'(rand_bits(4));
        for (i = 0; i < len; i++) begin
            pick   = int'(rand_bits(5));
            target = i + 1 + int'(rand_bits(2));
            if (target > len) begin
                target = len;  // end is the furthest target
            end
            case (pick)
                2, 3:    emit(OP_STAC, 0);
                4:       emit(OP_MVAC, 0);
                5:       emit(OP_MVACR1, 0);
                6:       emit(OP_MVACR2, 0);
                7:       emit(OP_MVACR3, 0);
                8:       emit(OP_MVACR4, 0);
                9:       emit(OP_MVR1AC, 0);
                10:      emit(OP_MVR2AC, 0);
                11:      emit(OP_MVR3AC, 0);
                12:      emit(OP_MVR4AC, 0);
                13, 14:  emit(OP_ADD, 0);
                15:      emit(OP_SUB, 0);
                16:      emit(OP_MULT, 0);
                17:      emit(OP_LSHIFT, 0);
                18:      emit(OP_INAC, 0);
                19:      emit(OP_CLAC, 0);
                20:      emit(OP_NOP, 0);
                21, 22:  emit(OP_JPNZ, target);
                23, 24:  emit(OP_JMPZ, target);
                25:      emit(6'd40, 0);  // unused code
                default: emit(OP_LDIAC, int'(rand_bits(5)));
            endcase
        end
        emit(OP_END, 0);
        run_test("random program");
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        run        = 1'b0;
        host_we    = 1'b0;
        host_sel   = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        rd_check   = 1'b0;
        lfsr       = 16'd52523;
        test_num   = 0;
        tb_errors  = 0;
        aborted    = 1'b0;
        apply_reset();
        fill_memories();
        load_store_test();
        repeat (3) alu_test();
        branch_test();
        countdown_test();
        repeat (20) random_program_test();
        $display("checks passed %0d, failed %0d, other errors %0d", pass_count, fail_count,
                 tb_errors);
        if (fail_count == 0 && tb_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/cpu_checker.sv
`default_nettype none

`include "cpu_params.svh"

module cpu_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                host_we,
    input  logic                host_sel,
    input  datapath_pkg::addr_t host_addr,
    input  datapath_pkg::word_t host_wdata,
    input  datapath_pkg::word_t host_rdata,
    input  logic                rd_check,
    input  logic                busy,
    input  logic                done,
    input  datapath_pkg::word_t ac,
    output int                  pass_count,
    output int                  fail_count
);
    import isa_pkg::*;
    import datapath_pkg::*;

    localparam int STEP_LIMIT = 4000;

    word_t model_im [`CPU_IM_DEPTH];
    word_t model_dm [`CPU_DM_DEPTH];
    word_t model_ac = '0;
    logic  done_q = 1'b0;
    logic  run_q = 1'b0;
    int    passes = 0;
    int    fails = 0;

    assign pass_count = passes;
    assign fail_count = fails;

    function automatic void compare(string name, word_t expected, word_t actual);
        if (expected === actual) begin
            passes++;
        end else begin
            fails++;
            $display("CHECK FAILED time %0t %s: expected %h, actual %h", $time, name,
                     expected, actual);
        end
    endfunction

    // instruction-level model, registers start from reset values
    task automatic run_model();
        addr_t pc;
        addr_t ar;
        word_t ir;
        word_t acc;
        word_t r;
        word_t rn [1:4];
        int    steps;
        logic  halted;
        pc     = '0;
        ar     = '0;
        acc    = '0;
        r      = '0;
        rn     = '{default: '0};
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < STEP_LIMIT) begin
            ir = model_im[pc];
            pc = pc + addr_t'(1);
            steps++;
            case (ir[`CPU_WORD_W-1 -: `CPU_OPC_W])
                OP_LDAC: begin
                    ar  = acc[`CPU_ADDR_W-1:0];
                    acc = model_dm[ar];
                end
                OP_LDIAC: begin
                    ar  = ir[`CPU_ADDR_W-1:0];
                    acc = model_dm[ar];
                end
                OP_STAC:   model_dm[ar] = acc;
                OP_MVAC:   r = acc;
                OP_MVACAR: ar = acc[`CPU_ADDR_W-1:0];
                OP_MVACR1: rn[1] = acc;
                OP_MVACR2: rn[2] = acc;
                OP_MVACR3: rn[3] = acc;
                OP_MVACR4: rn[4] = acc;
                OP_MVR1AC: acc = rn[1];
                OP_MVR2AC: acc = rn[2];
                OP_MVR3AC: acc = rn[3];
                OP_MVR4AC: acc = rn[4];
                OP_ADD:    acc = acc + r;
                OP_SUB:    acc = acc - r;
                OP_MULT:   acc = acc * r;
                OP_LSHIFT: acc = acc << r[3:0];
                OP_INAC:   acc = acc + word_t'(1);
                OP_CLAC:   acc = '0;
                OP_JPNZ: begin
                    if (acc != '0) begin
                        pc = ir[`CPU_ADDR_W-1:0];
                    end
                end
                OP_JMPZ: begin
                    if (acc == '0) begin
                        pc = ir[`CPU_ADDR_W-1:0];
                    end
                end
                OP_END:    halted = 1'b1;
                default:   ;  // nop and unused codes
            endcase
        end
        if (!halted) begin
            fails++;
            $display("model did not reach END within %0d steps", STEP_LIMIT);
        end
        model_ac = acc;
    endtask

    always @(posedge clk) begin
        done_q <= done;
        run_q  <= run;
        if (host_we) begin
            if (host_sel) begin
                model_dm[host_addr] = host_wdata;
            end else begin
                model_im[host_addr] = host_wdata;
            end
        end
        if (run) begin
            compare("busy before run", '0, word_t'(busy));  // still idle after reset
            compare("done before run", '0, word_t'(done));
            compare("ac before run", '0, ac);
            run_model();
        end
        if (run_q) begin
            compare("busy after run", word_t'(1'b1), word_t'(busy));
        end
        if (done && !done_q) begin
            compare("ac", model_ac, ac);
            compare("busy at done", '0, word_t'(busy));
        end
        if (done_q && !done && !reset) begin
            fails++;
            $display("done dropped at time %0t without a reset", $time);
        end
        if (rd_check) begin
            compare($sformatf("host_rdata dm[%0d]", host_addr), model_dm[host_addr],
                    host_rdata);
        end
    end

endmodule

`default_nettype wire

//--- logic/accumulator_cpu.sv
`default_nettype none

`include "cpu_params.svh"

module accumulator_cpu (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                host_we,
    input  logic                host_sel,
    input  datapath_pkg::addr_t host_addr,
    input  datapath_pkg::word_t host_wdata,
    output datapath_pkg::word_t host_rdata,
    output logic                busy,
    output logic                done,
    output datapath_pkg::word_t ac
);
    import isa_pkg::*;
    import datapath_pkg::*;

    reg_en_t  write_en;
    reg_en_t  inc_en;
    reg_en_t  clr_en;
    bus_src_t read_en;
    alu_op_t  alu_op;
    opcode_t  opcode;
    logic     z;
    logic     mem_we;
    addr_t    pc;
    addr_t    ar;
    word_t    r;
    word_t    im_data;
    word_t    dm_data;
    word_t    alu_result;
    word_t    im_host_rdata;
    word_t    dm_host_rdata;

    assign host_rdata = host_sel ? dm_host_rdata : im_host_rdata;  // 1 selects dm

    control_unit u_control (
        .clk, .reset, .run, .opcode, .z,
        .write_en, .inc_en, .clr_en, .read_en, .alu_op,
        .mem_we, .busy, .done
    );

    register_bank u_regs (
        .clk, .reset, .write_en, .inc_en, .clr_en, .read_en,
        .im_data, .dm_data, .alu_result,
        .pc, .ar, .ac, .r, .opcode, .z
    );

    alu u_alu (
        .clk, .reset, .alu_op,
        .operands_to_alu (write_en[`CPU_SLOT_OPS_TO_ALU]),
        .ac, .r,
        .result          (alu_result)
    );

    memory_array #(.DEPTH(`CPU_IM_DEPTH)) im (
        .clk,
        .addr       (pc),
        .we         (1'b0),
        .wdata      ('0),
        .rdata      (im_data),
        .host_we    (host_we && !host_sel),
        .host_addr,
        .host_wdata,
        .host_rdata (im_host_rdata)
    );

    memory_array #(.DEPTH(`CPU_DM_DEPTH)) dm (
        .clk,
        .addr       (ar),
        .we         (mem_we),
        .wdata      (ac),
        .rdata      (dm_data),
        .host_we    (host_we && host_sel),
        .host_addr,
        .host_wdata,
        .host_rdata (dm_host_rdata)
    );

endmodule

`default_nettype wire

//--- logic/memory_array.sv
`default_nettype none

`include "cpu_params.svh"

module memory_array #(
    parameter int DEPTH = `CPU_DM_DEPTH
) (
    input  logic                clk,
    input  datapath_pkg::addr_t addr,
    input  logic                we,
    input  datapath_pkg::word_t wdata,
    output datapath_pkg::word_t rdata,
    input  logic                host_we,
    input  datapath_pkg::addr_t host_addr,
    input  datapath_pkg::word_t host_wdata,
    output datapath_pkg::word_t host_rdata
);
    import datapath_pkg::*;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;  // core port has priority
        end else if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
    end

    assign rdata      = mem[addr];
    assign host_rdata = mem[host_addr];

    // host only writes while the core is idle
    a_port_excl: assert property (@(posedge clk) !(we && host_we));

endmodule

`default_nettype wire

//--- logic/register_bank.sv
`default_nettype none

`include "cpu_params.svh"

module register_bank (
    input  logic                   clk,
    input  logic                   reset,
    input  datapath_pkg::reg_en_t  write_en,
    input  datapath_pkg::reg_en_t  inc_en,
    input  datapath_pkg::reg_en_t  clr_en,
    input  datapath_pkg::bus_src_t read_en,
    input  datapath_pkg::word_t    im_data,
    input  datapath_pkg::word_t    dm_data,
    input  datapath_pkg::word_t    alu_result,
    output datapath_pkg::addr_t    pc,
    output datapath_pkg::addr_t    ar,
    output datapath_pkg::word_t    ac,
    output datapath_pkg::word_t    r,
    output isa_pkg::opcode_t       opcode,
    output logic                   z
);
    import isa_pkg::*;
    import datapath_pkg::*;

    word_t ir;
    word_t r1;
    word_t r2;
    word_t r3;
    word_t r4;
    word_t bus;

    // clear beats load, load beats increment
    function automatic word_t next_word(word_t cur, word_t d, logic wr, logic inc, logic clr);
        if (clr) begin
            return '0;
        end
        if (wr) begin
            return d;
        end
        return inc ? cur + 1'b1 : cur;
    endfunction

    always_comb begin
        case (read_en)
            SRC_IR:  bus = ir;
            SRC_AC:  bus = ac;
            SRC_R1:  bus = r1;
            SRC_R2:  bus = r2;
            SRC_R3:  bus = r3;
            SRC_R4:  bus = r4;
            SRC_DM:  bus = dm_data;
            SRC_IM:  bus = im_data;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ar <= '0;
            ir <= '0;
            ac <= '0;
            r  <= '0;
            r1 <= '0;
            r2 <= '0;
            r3 <= '0;
            r4 <= '0;
        end else begin
            if (clr_en[`CPU_SLOT_PC]) begin
                pc <= '0;
            end else if (write_en[`CPU_SLOT_PC]) begin
                pc <= ir[`CPU_ADDR_W-1:0];  // jump target
            end else if (inc_en[`CPU_SLOT_PC]) begin
                pc <= pc + 1'b1;
            end
            if (clr_en[`CPU_SLOT_AR]) begin
                ar <= '0;
            end else if (write_en[`CPU_SLOT_AR]) begin
                ar <= bus[`CPU_ADDR_W-1:0];
            end else if (inc_en[`CPU_SLOT_AR]) begin
                ar <= ar + 1'b1;
            end
            if (write_en[`CPU_SLOT_ALU_TO_AC]) begin
                ac <= alu_result;
            end else begin
                ac <= next_word(ac, bus, write_en[`CPU_SLOT_AC], inc_en[`CPU_SLOT_AC],
                                clr_en[`CPU_SLOT_AC]);
            end
            ir <= next_word(ir, bus, write_en[`CPU_SLOT_IR], inc_en[`CPU_SLOT_IR],
                            clr_en[`CPU_SLOT_IR]);
            r  <= next_word(r, bus, write_en[`CPU_SLOT_R], inc_en[`CPU_SLOT_R],
                            clr_en[`CPU_SLOT_R]);
            r1 <= next_word(r1, bus, write_en[`CPU_SLOT_R1], inc_en[`CPU_SLOT_R1],
                            clr_en[`CPU_SLOT_R1]);
            r2 <= next_word(r2, bus, write_en[`CPU_SLOT_R2], inc_en[`CPU_SLOT_R2],
                            clr_en[`CPU_SLOT_R2]);
            r3 <= next_word(r3, bus, write_en[`CPU_SLOT_R3], inc_en[`CPU_SLOT_R3],
                            clr_en[`CPU_SLOT_R3]);
            r4 <= next_word(r4, bus, write_en[`CPU_SLOT_R4], inc_en[`CPU_SLOT_R4],
                            clr_en[`CPU_SLOT_R4]);
        end
    end

    assign opcode = opcode_t'(ir[`CPU_WORD_W-1 -: `CPU_OPC_W]);
    assign z      = (ac == '0);

    // the control unit never loads and counts the same register
    a_no_wr_inc: assert property (@(posedge clk) disable iff (reset)
        (write_en & inc_en) == '0);

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
    input  logic                clk,
    input  logic                reset,
    input  isa_pkg::alu_op_t    alu_op,
    input  logic                operands_to_alu,
    input  datapath_pkg::word_t ac,
    input  datapath_pkg::word_t r,
    output datapath_pkg::word_t result
);
    import isa_pkg::*;
    import datapath_pkg::*;

    word_t op_result;

    // all results are cut to the word width
    always_comb begin
        case (alu_op)
            ALU_ADD:    op_result = ac + r;
            ALU_SUB:    op_result = ac - r;
            ALU_MULT:   op_result = ac * r;         // low half of product
            ALU_LSHIFT: op_result = ac << r[3:0];
            default:    op_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (operands_to_alu) begin
            result <= op_result;
        end
    end

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`default_nettype none

`include "cpu_params.svh"

module control_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  isa_pkg::opcode_t       opcode,
    input  logic                   z,
    output datapath_pkg::reg_en_t  write_en,
    output datapath_pkg::reg_en_t  inc_en,
    output datapath_pkg::reg_en_t  clr_en,
    output datapath_pkg::bus_src_t read_en,
    output isa_pkg::alu_op_t       alu_op,
    output logic                   mem_we,
    output logic                   busy,
    output logic                   done
);
    import isa_pkg::*;
    import datapath_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_START;
            done  <= 1'b0;
        end else begin
            state <= next_state;
            done  <= (state == S_ENDOP);  // one cycle behind ENDOP
        end
    end

    assign busy   = (state != S_START) && (state != S_ENDOP);
    assign mem_we = write_en[`CPU_SLOT_DM];

    always_comb begin
        write_en   = '0;
        inc_en     = '0;
        clr_en     = '0;
        read_en    = SRC_NONE;
        alu_op     = ALU_NONE;
        next_state = S_FETCH1;
        case (state)
            S_START:  next_state = run ? S_FETCH1 : S_START;
            S_FETCH1: begin
                read_en                = SRC_IM;
                write_en[`CPU_SLOT_IR] = 1'b1;
                next_state             = S_FETCH2;
            end
            S_FETCH2: begin
                inc_en[`CPU_SLOT_PC] = 1'b1;
                case (opcode)
                    OP_LDAC, OP_LDIAC, OP_STAC, OP_MVAC, OP_MVACAR, OP_MVACR1, OP_MVACR2,
                    OP_MVACR3, OP_MVACR4, OP_MVR1AC, OP_MVR2AC, OP_MVR3AC, OP_MVR4AC,
                    OP_ADD, OP_MULT, OP_LSHIFT, OP_SUB, OP_INAC, OP_JPNZ, OP_JMPZ,
                    OP_NOP, OP_CLAC, OP_END: next_state = ctrl_state_t'(opcode);
                    default:                 next_state = S_FETCH1;  // unknown acts as nop
                endcase
            end
            S_LDAC: begin
                read_en                = SRC_AC;
                write_en[`CPU_SLOT_AR] = 1'b1;
                next_state             = S_LDAC2;
            end
            S_LDIAC: begin
                read_en                = SRC_IR;  // ar keeps the address field
                write_en[`CPU_SLOT_AR] = 1'b1;
                next_state             = S_LDIAC2;
            end
            S_LDAC2, S_LDIAC2: begin
                read_en                = SRC_DM;
                write_en[`CPU_SLOT_AC] = 1'b1;
            end
            S_STAC: begin
                read_en    = SRC_AC;
                next_state = S_STAC2;
            end
            S_STAC2: begin
                read_en                = SRC_AC;
                write_en[`CPU_SLOT_DM] = 1'b1;
            end
            S_MVAC, S_MVACAR, S_MVACR1, S_MVACR2, S_MVACR3, S_MVACR4: begin
                read_en = SRC_AC;
                case (state)
                    S_MVAC:   write_en[`CPU_SLOT_R]  = 1'b1;
                    S_MVACAR: write_en[`CPU_SLOT_AR] = 1'b1;
                    S_MVACR1: write_en[`CPU_SLOT_R1] = 1'b1;
                    S_MVACR2: write_en[`CPU_SLOT_R2] = 1'b1;
                    S_MVACR3: write_en[`CPU_SLOT_R3] = 1'b1;
                    default:  write_en[`CPU_SLOT_R4] = 1'b1;
                endcase
            end
            S_MVR1AC, S_MVR2AC, S_MVR3AC, S_MVR4AC: begin
                write_en[`CPU_SLOT_AC] = 1'b1;
                case (state)
                    S_MVR1AC: read_en = SRC_R1;
                    S_MVR2AC: read_en = SRC_R2;
                    S_MVR3AC: read_en = SRC_R3;
                    default:  read_en = SRC_R4;
                endcase
            end
            S_ADD, S_SUB, S_MULT, S_LSHIFT: begin
                write_en[`CPU_SLOT_OPS_TO_ALU] = 1'b1;  // alu latches its result
                case (state)
                    S_ADD: begin
                        alu_op     = ALU_ADD;
                        next_state = S_ADD2;
                    end
                    S_SUB: begin
                        alu_op     = ALU_SUB;
                        next_state = S_SUB2;
                    end
                    S_MULT: begin
                        alu_op     = ALU_MULT;
                        next_state = S_MULT2;
                    end
                    default: begin
                        alu_op     = ALU_LSHIFT;
                        next_state = S_LSHIFT2;
                    end
                endcase
            end
            S_ADD2, S_SUB2, S_MULT2, S_LSHIFT2: write_en[`CPU_SLOT_ALU_TO_AC] = 1'b1;
            S_INAC:  inc_en[`CPU_SLOT_AC] = 1'b1;
            S_CLAC:  clr_en[`CPU_SLOT_AC] = 1'b1;
            S_JPNZ:  next_state = z ? S_FETCH1 : S_JPNZ2;
            S_JMPZ:  next_state = z ? S_JMPZ2 : S_FETCH1;
            S_JPNZ2, S_JMPZ2: begin
                read_en                = SRC_IR;
                write_en[`CPU_SLOT_PC] = 1'b1;  // pc takes the address field
            end
            S_END:   next_state = S_ENDOP;
            S_ENDOP: next_state = S_ENDOP;
            default: next_state = S_FETCH1;
        endcase
    end

    // every bus load has a source on the bus
    a_bus_src: assert property (@(posedge clk) disable iff (reset)
        (|write_en[`CPU_SLOT_R1:`CPU_SLOT_AR]) |-> (read_en != SRC_NONE));

    a_mem_we: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> (state == S_STAC2) && ($past(state) == S_STAC));

    a_done: assert property (@(posedge clk) disable iff (reset)
        done |-> (state == S_ENDOP) && ($past(state) == S_ENDOP));

endmodule

`default_nettype wire

//--- logic/datapath_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package datapath_pkg;

    typedef logic [`CPU_WORD_W-1:0]  word_t;
    typedef logic [`CPU_ADDR_W-1:0]  addr_t;
    typedef logic [`CPU_NREG_EN-1:0] reg_en_t;  // one bit per slot

    // sources of the shared bus
    typedef enum logic [3:0] {
        SRC_NONE = 4'd0,
        SRC_IR   = 4'd4,
        SRC_AC   = 4'd5,
        SRC_R1   = 4'd7,
        SRC_R2   = 4'd8,
        SRC_R3   = 4'd9,
        SRC_R4   = 4'd10,
        SRC_DM   = 4'd12,
        SRC_IM   = 4'd13
    } bus_src_t;

endpackage

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package isa_pkg;

    // code of each opcode is also its first execute state
    typedef enum logic [`CPU_OPC_W-1:0] {
        OP_LDAC   = 6'd3,  OP_LDIAC  = 6'd5,  OP_STAC   = 6'd8,
        OP_MVAC   = 6'd9,  OP_MVACAR = 6'd10,
        OP_MVACR1 = 6'd11, OP_MVACR2 = 6'd12, OP_MVACR3 = 6'd13, OP_MVACR4 = 6'd14,
        OP_MVR1AC = 6'd15, OP_MVR2AC = 6'd16, OP_MVR3AC = 6'd17, OP_MVR4AC = 6'd18,
        OP_ADD    = 6'd19, OP_MULT   = 6'd20, OP_LSHIFT = 6'd21, OP_SUB    = 6'd22,
        OP_INAC   = 6'd23, OP_JPNZ   = 6'd24, OP_JMPZ   = 6'd26, OP_NOP    = 6'd28,
        OP_CLAC   = 6'd30, OP_END    = 6'd31
    } opcode_t;

    typedef enum logic [5:0] {
        S_START   = 6'd0,  S_FETCH1  = 6'd1,  S_FETCH2  = 6'd2,
        S_LDAC    = 6'd3,  S_LDAC2   = 6'd4,  S_LDIAC   = 6'd5,  S_LDIAC2  = 6'd6,
        S_STAC    = 6'd8,  S_MVAC    = 6'd9,  S_MVACAR  = 6'd10,
        S_MVACR1  = 6'd11, S_MVACR2  = 6'd12, S_MVACR3  = 6'd13, S_MVACR4  = 6'd14,
        S_MVR1AC  = 6'd15, S_MVR2AC  = 6'd16, S_MVR3AC  = 6'd17, S_MVR4AC  = 6'd18,
        S_ADD     = 6'd19, S_MULT    = 6'd20, S_LSHIFT  = 6'd21, S_SUB     = 6'd22,
        S_INAC    = 6'd23, S_JPNZ    = 6'd24, S_JPNZ2   = 6'd25,
        S_JMPZ    = 6'd26, S_JMPZ2   = 6'd27, S_NOP     = 6'd28,
        S_CLAC    = 6'd30, S_END     = 6'd31,
        S_STAC2   = 6'd32, S_ADD2    = 6'd33, S_SUB2    = 6'd34,
        S_MULT2   = 6'd35, S_LSHIFT2 = 6'd36, S_ENDOP   = 6'd37
    } ctrl_state_t;

    typedef enum logic [2:0] {
        ALU_NONE   = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_MULT   = 3'd3,
        ALU_LSHIFT = 3'd4
    } alu_op_t;

endpackage

`default_nettype wire

//--- logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_WORD_W          16
`define CPU_ADDR_W          10
`define CPU_OPC_W           6
`define CPU_IM_DEPTH        1024
`define CPU_DM_DEPTH        1024
`define CPU_NREG_EN         16

// bit positions in the write, increment and clear enables
`define CPU_SLOT_PC         1
`define CPU_SLOT_AR         2
`define CPU_SLOT_IR         3
`define CPU_SLOT_AC         4
`define CPU_SLOT_R          5
`define CPU_SLOT_R4         7
`define CPU_SLOT_R3         8
`define CPU_SLOT_R2         9
`define CPU_SLOT_R1         10
`define CPU_SLOT_DM         11
`define CPU_SLOT_ALU_TO_AC  12
`define CPU_SLOT_OPS_TO_ALU 14

`endif
